/* Makefile */
# Verilator build and run of the element reduction testbench

VERILATOR  ?= verilator
TOP        ?= tb_elem_reduce
DUT_TOP    ?= elem_reduce_top
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(wildcard verilog/*.sv verilog/*.svh dv/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides pass or fail
run: build
	./$(SIM_BIN) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_elem_reduce.sv */
/*
 * Testbench for the element reduction path. Results are checked by concurrent assertions
 * against a queue of modelled values and due cycles. Starts follow the DUT's start rule.
 */

`timescale 1ns/1ps

`include "elem_defines.svh"

module tb_elem_reduce
    import elem_pkg::*;
;

    localparam int NUM_OPS = 40;
    localparam int TIMEOUT = NUM_OPS * (16 + `ELEM_PIPE_DEPTH + 4) + 100;

    logic clk_i;
    logic async_rst_ni;
    logic start_i;
    elem_op_e op_i;
    sew_e sew_i;
    vl_t vl_i;
    xword_t init_i;
    vreg_t vreg_i;
    logic busy_o;
    logic result_valid_o;
    xword_t result_o;

    // expected results in order of start with one slot per operation
    xword_t exp_mem [64];
    int due_mem [64];
    string name_mem [64];
    logic [5:0] wr_ptr = '0;
    logic [5:0] rd_ptr = '0;
    logic head_valid;
    xword_t head_exp;
    int head_due;

    int cyc = 0;
    int busy_from = 1;
    int busy_to = 0;
    logic busy_exp;
    logic started = 1'b0;
    string cur_name = "reset";
    logic pulse_d = 1'b0;
    logic due_d = 1'b0;
    logic [31:0] lfsr_q = 32'hcb44_c85e;

    int err_idle = 0;
    int err_busy = 0;
    int err_orphan = 0;
    int err_late = 0;
    int err_value = 0;
    int err_missing = 0;
    int errs_seen = 0;
    int pass_cnt = 0;
    int fail_cnt = 0;

    assign head_valid = (wr_ptr != rd_ptr);
    assign head_exp = exp_mem[rd_ptr];
    assign head_due = due_mem[rd_ptr];
    assign busy_exp = (cyc >= busy_from) && (cyc <= busy_to);

    elem_reduce_top u_elem_reduce_top (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .start_i        (start_i),
        .op_i           (op_i),
        .sew_i          (sew_i),
        .vl_i           (vl_i),
        .init_i         (init_i),
        .vreg_i         (vreg_i),
        .busy_o         (busy_o),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    //////////////////////////////
    // random data and reference model

    // fibonacci lfsr on x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(int nbits);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic vreg_t rand_vreg();
        return {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
    endfunction

    function automatic int sew_bits(sew_e sew);
        return (sew == SEW_8) ? 8 : (sew == SEW_16) ? 16 : 32;
    endfunction

    function automatic int nbeats(elem_op_e op, sew_e sew);
        return (op == OP_XMV) ? 1 : `ELEM_VREG_W / sew_bits(sew);
    endfunction

    // value of the low w bits read as a signed number
    function automatic int signed_at(logic [31:0] v, int w);
        return $signed(v << (32 - w)) >>> (32 - w);
    endfunction

    function automatic xword_t model_result(elem_op_e op, sew_e sew, vl_t vl, xword_t init,
                                            vreg_t vreg);
        int w;
        logic [31:0] mask;
        logic [31:0] acc;
        logic [31:0] e;
        w = sew_bits(sew);
        mask = (w == 32) ? 32'hffff_ffff : ((32'h1 << w) - 1);
        acc = init & mask;
        if (op == OP_XMV) begin
            acc = vreg[31:0] & mask;
        end else begin
            for (int i = 0; i < `ELEM_VREG_W / w; i++) begin
                e = 32'(vreg >> (i * w)) & mask;
                if (i < int'(vl)) begin
                    case (op)
                        OP_SUM:  acc = (acc + e) & mask;
                        OP_AND:  acc = acc & e;
                        OP_OR:   acc = acc | e;
                        OP_XOR:  acc = acc ^ e;
                        OP_MINU: acc = (e < acc) ? e : acc;
                        OP_MAXU: acc = (e > acc) ? e : acc;
                        OP_MIN:  acc = (signed_at(e, w) < signed_at(acc, w)) ? e : acc;
                        default: acc = (signed_at(e, w) > signed_at(acc, w)) ? e : acc;
                    endcase
                end
            end
        end
        return xword_t'(signed_at(acc, w));
    endfunction

    function automatic int total_errs();
        return err_idle + err_busy + err_orphan + err_late + err_value + err_missing;
    endfunction

    //////////////////////////////
    // checks

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        pulse_d <= result_valid_o;
        due_d <= head_valid && (cyc == head_due);
    end

    a_idle_after_reset: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        !started |-> (!busy_o && !result_valid_o)
    ) else begin
        $display("busy_o or result_valid_o high before the first start");
        err_idle++;
    end

    a_busy_level: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        busy_o == busy_exp
    ) else begin
        $display("CHECK FAILED %s busy_o expected %b actual %b", cur_name,
                 $sampled(busy_exp), $sampled(busy_o));
        err_busy++;
    end

    a_pulse_expected: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        result_valid_o |-> head_valid
    ) else begin
        $display("result pulse at cycle %0d with no operation outstanding", $sampled(cyc));
        err_orphan++;
    end

    a_pulse_on_time: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        (result_valid_o && head_valid) |-> (cyc == head_due)
    ) else begin
        $display("%s result came at cycle %0d but was due at cycle %0d",
                 name_mem[rd_ptr], $sampled(cyc), head_due);
        err_late++;
    end

    a_result_value: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        (result_valid_o && head_valid) |-> (result_o == head_exp)
    ) else begin
        $display("CHECK FAILED %s expected %08h actual %08h", name_mem[rd_ptr], head_exp,
                 $sampled(result_o));
        err_value++;
    end

    a_no_missing: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        (head_valid && cyc == head_due) |-> result_valid_o
    ) else begin
        $display("%s gave no result pulse at its due cycle %0d", name_mem[rd_ptr], head_due);
        err_missing++;
    end

    // retire the head after its pulse or its due cycle has been checked
    always @(negedge clk_i) begin
        if (head_valid && (pulse_d || due_d)) begin
            if (total_errs() == errs_seen) begin
                $display("test %s ok, result %08h", name_mem[rd_ptr], head_exp);
                pass_cnt++;
            end else begin
                $display("test %s failed", name_mem[rd_ptr]);
                fail_cnt++;
            end
            errs_seen = total_errs();
            rd_ptr = rd_ptr + 1'b1;
        end
    end

    //////////////////////////////
    // stimulus

    // call 2 ns after a rising edge, returns 2 ns after the accepting edge
    task automatic start_op(input string name, input elem_op_e op, input sew_e sew,
                            input vl_t vl, input xword_t init, input vreg_t vreg);
        int n;
        int acc_cyc;
        n = nbeats(op, sew);
        acc_cyc = cyc + 1;
        exp_mem[wr_ptr] = model_result(op, sew, vl, init, vreg);
        // cycle k after the accepting edge runs with cyc at acc_cyc + k - 1
        due_mem[wr_ptr] = acc_cyc + (n + `ELEM_PIPE_DEPTH + 1) - 1;
        name_mem[wr_ptr] = name;
        wr_ptr = wr_ptr + 1'b1;
        // a start on the last beat extends the current busy stretch
        if (acc_cyc > busy_to + 1) begin
            busy_from = acc_cyc;
        end
        busy_to = acc_cyc + n - 1;
        cur_name = name;
        started = 1'b1;
        op_i = op;
        sew_i = sew;
        vl_i = vl;
        init_i = init;
        vreg_i = vreg;
        start_i = 1'b1;
        @(posedge clk_i);
        #2;
        start_i = 1'b0;
    endtask

    task automatic wait_results();
        while (head_valid) begin
            @(posedge clk_i);
        end
        #2;
    endtask

    // second start lands in the cycle of the first one's last beat
    task automatic back_to_back(input string name, input elem_op_e op_a, input sew_e sew_a,
                                input elem_op_e op_b, input sew_e sew_b);
        start_op({name, "_a"}, op_a, sew_a, vl_t'(nbeats(op_a, sew_a)), rand_bits(32),
                 rand_vreg());
        repeat (nbeats(op_a, sew_a) - 1) @(posedge clk_i);
        #2;
        start_op({name, "_b"}, op_b, sew_b, vl_t'(nbeats(op_b, sew_b) - 1), rand_bits(32),
                 rand_vreg());
        wait_results();
    endtask

    initial begin
        sew_e sew;
        elem_op_e op;
        int n;
        vl_t vl;
        async_rst_ni = 1'b0;
        start_i = 1'b0;
        op_i = OP_SUM;
        sew_i = SEW_8;
        vl_i = '0;
        init_i = '0;
        vreg_i = '0;
        repeat (10) @(posedge clk_i);
        #2;
        async_rst_ni = 1'b1;
        // idle outputs are watched by the assertions meanwhile
        repeat (5) @(posedge clk_i);
        #2;
        for (int s = 0; s < 3; s++) begin
            for (int o = 0; o < 8; o++) begin
                sew = sew_e'(s);
                op = elem_op_e'(o);
                start_op($sformatf("full_%s_sew%0d", op.name(), sew_bits(sew)), op, sew,
                         vl_t'(nbeats(op, sew)), rand_bits(32), rand_vreg());
                wait_results();
            end
        end
        // vl of 0, 1 and a random partial length at each width
        for (int s = 0; s < 3; s++) begin
            for (int k = 0; k < 3; k++) begin
                sew = sew_e'(s);
                op = elem_op_e'((s * 3 + k) % 8);
                n = nbeats(op, sew);
                vl = (k == 2) ? vl_t'(2 + rand_bits(8) % (n - 2)) : vl_t'(k);
                start_op($sformatf("vl%0d_%s_sew%0d", vl, op.name(), sew_bits(sew)), op, sew,
                         vl, rand_bits(32), rand_vreg());
                wait_results();
            end
        end
        for (int s = 0; s < 3; s++) begin
            sew = sew_e'(s);
            start_op($sformatf("xmv_sew%0d", sew_bits(sew)), OP_XMV, sew, vl_t'(rand_bits(8)),
                     rand_bits(32), rand_vreg());
            wait_results();
        end
        back_to_back("b2b_sum_max", OP_SUM, SEW_8, OP_MAX, SEW_16);
        back_to_back("b2b_xor_minu", OP_XOR, SEW_32, OP_MINU, SEW_32);
        repeat (5) @(posedge clk_i);
        if (pass_cnt + fail_cnt != NUM_OPS) begin
            $display("only %0d of %0d operations were retired", pass_cnt + fail_cnt, NUM_OPS);
        end
        $display("tests passed %0d, failed %0d, assertion errors %0d", pass_cnt, fail_cnt,
                 total_errs());
        if (fail_cnt == 0 && total_errs() == 0 && pass_cnt == NUM_OPS) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        while (cyc < TIMEOUT) begin
            @(posedge clk_i);
        end
        $display("run stopped after %0d cycles without finishing", cyc);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* flist.f */
+incdir+verilog
verilog/elem_pkg.sv
verilog/elem_sequencer.sv
verilog/elem_delay_line.sv
verilog/reduce_alu.sv
verilog/elem_reduce_top.sv
dv/tb_elem_reduce.sv

/* verilog/elem_defines.svh */
/*
 * Global sizes of the element reduction unit. The RTL assumes ELEM_XLEN is 32 and
 * that ELEM_VREG_W is a multiple of 32. ELEM_VL_W must hold the element count at SEW 8.
 */

`ifndef ELEM_DEFINES_SVH
`define ELEM_DEFINES_SVH

// width of one vector register in bits
`define ELEM_VREG_W 128

// scalar result and element lane width
`define ELEM_XLEN 32

// vl counts elements, up to VREG_W/8 at the narrowest element width
`define ELEM_VL_W 8

// register stages between the sequencer and the ALU
`define ELEM_PIPE_DEPTH 2

`endif

/* verilog/elem_delay_line.sv */
/*
 * Fixed latency of DEPTH cycles between sequencer and ALU, no stall. DEPTH must be
 * at least 1. Only the valid bits are reset.
 */

`timescale 1ns/1ps

`include "elem_defines.svh"

module elem_delay_line
    import elem_pkg::*;
#(
    parameter int unsigned DEPTH = `ELEM_PIPE_DEPTH
) (
    input  logic       clk_i,
    input  logic       async_rst_ni,
    input  elem_beat_t beat_i,
    output elem_beat_t beat_o
);

    if (DEPTH < 1) begin : g_depth_check
        $fatal(1, "elem_delay_line needs DEPTH of at least 1, got %0d", DEPTH);
    end

    logic [DEPTH-1:0] valid_q;
    elem_beat_t       stage_q [DEPTH];

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= beat_i.valid;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // beat payload moves along with its valid bit
    always_ff @(posedge clk_i) begin
        stage_q[0] <= beat_i;
        for (int i = 1; i < DEPTH; i++) begin
            stage_q[i] <= stage_q[i-1];
        end
    end

    always_comb begin
        beat_o       = stage_q[DEPTH-1];
        beat_o.valid = valid_q[DEPTH-1];
    end

endmodule

/* verilog/elem_pkg.sv */
/*
 * Types shared by the element reduction path. The widths come from elem_defines.svh.
 */

`include "elem_defines.svh"

package elem_pkg;

    // plain vectors with a meaning
    typedef logic [`ELEM_VREG_W-1:0] vreg_t;
    typedef logic [`ELEM_XLEN-1:0]   xword_t;
    typedef logic [`ELEM_VL_W-1:0]   vl_t;

    // element width
    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32
    } sew_e;

    // reductions plus the element 0 move
    typedef enum logic [3:0] {
        OP_SUM,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MINU,
        OP_MIN,
        OP_MAXU,
        OP_MAX,
        OP_XMV
    } elem_op_e;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_e;

    // one element travelling from the sequencer to the ALU
    typedef struct packed {
        logic     valid;
        logic     first;
        logic     last;
        logic     active;
        elem_op_e op;
        sew_e     sew;
        xword_t   data;
        xword_t   init;
    } elem_beat_t;

endpackage

/* verilog/elem_reduce_top.sv */
/*
 * Reduction path of the element unit: sequencer, delay line, ALU. No handshake.
 * start_i is a strobe and the result arrives as a one-cycle pulse.
 */

`timescale 1ns/1ps

module elem_reduce_top
    import elem_pkg::*;
(
    input  logic     clk_i,
    input  logic     async_rst_ni,

    input  logic     start_i,
    input  elem_op_e op_i,
    input  sew_e     sew_i,
    input  vl_t      vl_i,
    input  xword_t   init_i,
    input  vreg_t    vreg_i,

    output logic     busy_o,
    output logic     result_valid_o,
    output xword_t   result_o
);

    elem_beat_t seq_beat;
    elem_beat_t alu_beat;

    elem_sequencer u_elem_sequencer (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .start_i      (start_i),
        .op_i         (op_i),
        .sew_i        (sew_i),
        .vl_i         (vl_i),
        .init_i       (init_i),
        .vreg_i       (vreg_i),
        .beat_o       (seq_beat),
        .busy_o       (busy_o)
    );

    // stands in for the register read stages
    elem_delay_line u_elem_delay_line (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .beat_i       (seq_beat),
        .beat_o       (alu_beat)
    );

    reduce_alu u_reduce_alu (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .beat_i         (alu_beat),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

endmodule

/* verilog/elem_sequencer.sv */
/*
 * Walks one vector register, one element per cycle. A new start is only legal while
 * idle or in the cycle that emits the last beat. Other inputs count only with start_i.
 */

`timescale 1ns/1ps

`include "elem_defines.svh"

module elem_sequencer
    import elem_pkg::*;
(
    input  logic       clk_i,
    input  logic       async_rst_ni,

    input  logic       start_i,
    input  elem_op_e   op_i,
    input  sew_e       sew_i,
    input  vl_t        vl_i,
    input  xword_t     init_i,
    input  vreg_t      vreg_i,

    output elem_beat_t beat_o,
    output logic       busy_o
);

    //////////////////////////////
    // control state

    seq_state_e state_q;
    vl_t        idx_q;
    vl_t        last_idx_q;
    vl_t        last_idx_d;

    // operation held while running
    vreg_t      shreg_q;
    elem_op_e   op_q;
    sew_e       sew_q;
    vl_t        vl_q;
    xword_t     init_q;

    logic       run;
    logic       beat_last;
    logic       accept;

    assign run       = (state_q == SEQ_RUN);
    assign beat_last = run & (idx_q == last_idx_q);
    // the last beat hands over to the next operation without a bubble
    assign accept    = start_i & (~run | beat_last);

    // index of the final beat for the incoming operation
    always_comb begin
        unique case (sew_i)
            SEW_8:   last_idx_d = vl_t'(`ELEM_VREG_W / 8 - 1);
            SEW_16:  last_idx_d = vl_t'(`ELEM_VREG_W / 16 - 1);
            default: last_idx_d = vl_t'(`ELEM_VREG_W / 32 - 1);
        endcase
        // xmv only needs element 0
        if (op_i == OP_XMV) begin
            last_idx_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q    <= SEQ_IDLE;
            idx_q      <= '0;
            last_idx_q <= '0;
        end else if (accept) begin
            state_q    <= SEQ_RUN;
            idx_q      <= '0;
            last_idx_q <= last_idx_d;
        end else if (run) begin
            if (beat_last) begin
                state_q <= SEQ_IDLE;
            end
            idx_q <= idx_q + 1'b1;
        end
    end

    //////////////////////////////
    // operand register

    always_ff @(posedge clk_i) begin
        if (accept) begin
            shreg_q <= vreg_i;
            op_q    <= op_i;
            sew_q   <= sew_i;
            vl_q    <= vl_i;
            init_q  <= init_i;
        end else if (run) begin
            // drop the element just emitted
            unique case (sew_q)
                SEW_8:   shreg_q <= shreg_q >> 8;
                SEW_16:  shreg_q <= shreg_q >> 16;
                default: shreg_q <= shreg_q >> 32;
            endcase
        end
    end

    //////////////////////////////
    // beat output

    always_comb begin
        beat_o.valid  = run;
        beat_o.first  = run & (idx_q == '0);
        beat_o.last   = beat_last;
        beat_o.active = run & (idx_q < vl_q);
        beat_o.op     = op_q;
        beat_o.sew    = sew_q;
        beat_o.init   = init_q;
        // element 0 always sits in the low bits
        unique case (sew_q)
            SEW_8:   beat_o.data = xword_t'(shreg_q[7:0]);
            SEW_16:  beat_o.data = xword_t'(shreg_q[15:0]);
            default: beat_o.data = shreg_q[31:0];
        endcase
    end

    assign busy_o = run;

    // a start in the middle of an operation would be silently lost
    a_start_only_on_last: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        (start_i && state_q == SEQ_RUN) |-> beat_o.last
    ) else $error("start_i asserted while busy and not on the last beat");

endmodule

/* verilog/reduce_alu.sv */
/*
 * Folds a stream of beats into one scalar. Operations run at the element width and
 * the result is sign-extended. One result pulse per beat marked last.
 */

`timescale 1ns/1ps

module reduce_alu
    import elem_pkg::*;
(
    input  logic       clk_i,
    input  logic       async_rst_ni,
    input  elem_beat_t beat_i,
    output logic       result_valid_o,
    output xword_t     result_o
);

    //////////////////////////////
    // width helpers

    function automatic xword_t zext_sew(xword_t x, sew_e sew);
        xword_t r;
        unique case (sew)
            SEW_8:   r = xword_t'(x[7:0]);
            SEW_16:  r = xword_t'(x[15:0]);
            default: r = x;
        endcase
        return r;
    endfunction

    function automatic xword_t sext_sew(xword_t x, sew_e sew);
        xword_t r;
        unique case (sew)
            SEW_8:   r = xword_t'($signed(x[7:0]));
            SEW_16:  r = xword_t'($signed(x[15:0]));
            default: r = x;
        endcase
        return r;
    endfunction

    //////////////////////////////
    // datapath

    xword_t acc_q;
    xword_t operand;
    xword_t a_u;
    xword_t b_u;
    xword_t a_s;
    xword_t b_s;
    xword_t res;
    xword_t next_val;
    logic   result_valid_q;

    // first beat starts from init, later beats from the running value
    assign operand = beat_i.first ? beat_i.init : acc_q;

    // operands normalised for unsigned and signed compares at SEW
    assign a_u = zext_sew(beat_i.data, beat_i.sew);
    assign b_u = zext_sew(operand, beat_i.sew);
    assign a_s = sext_sew(beat_i.data, beat_i.sew);
    assign b_s = sext_sew(operand, beat_i.sew);

    always_comb begin
        unique case (beat_i.op)
            OP_SUM:  res = a_u + operand;
            OP_AND:  res = a_u & operand;
            OP_OR:   res = a_u | operand;
            OP_XOR:  res = a_u ^ operand;
            OP_MINU: res = (a_u < b_u) ? a_u : b_u;
            OP_MIN:  res = ($signed(a_s) < $signed(b_s)) ? a_s : b_s;
            OP_MAXU: res = (a_u > b_u) ? a_u : b_u;
            OP_MAX:  res = ($signed(a_s) > $signed(b_s)) ? a_s : b_s;
            default: res = a_u;
        endcase
        // elements past vl leave the value untouched, xmv ignores vl
        if (!beat_i.active && beat_i.op != OP_XMV) begin
            res = operand;
        end
        // upper bits above SEW are don't-care until here
        next_val = sext_sew(res, beat_i.sew);
    end

    //////////////////////////////
    // accumulator and result

    always_ff @(posedge clk_i) begin
        if (beat_i.valid) begin
            acc_q <= next_val;
        end
        if (beat_i.valid && beat_i.last) begin
            result_o <= next_val;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            result_valid_q <= 1'b0;
        end else begin
            result_valid_q <= beat_i.valid & beat_i.last;
        end
    end

    assign result_valid_o = result_valid_q;

    // last is set upstream by the sequencer and must survive the delay line
    a_last_has_valid: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        beat_i.last |-> beat_i.valid
    ) else $error("beat with last set arrived without valid");

endmodule
